//--- afifo_pkg.sv
package afifo_pkg;

   // widest pointer that the conversion functions handle
   localparam int MAX_ADDR_W = 16;

   // default geometry: 64 bytes written, 16 words of 32 bits read
   localparam int DEF_W_DATA_W = 8;
   localparam int DEF_R_DATA_W = 32;
   localparam int DEF_W_ADDR_W = 6;
   localparam int DEF_R_ADDR_W = 4;

   // decodes the low n bits of a gray value
   // bits at n and above come back as zero
   function automatic logic [MAX_ADDR_W-1:0] gray_to_bin(
      input logic [MAX_ADDR_W-1:0] gray,
      input int                    n
   );
      logic [MAX_ADDR_W-1:0] bin;

      bin = '0;
      for (int i = MAX_ADDR_W - 1; i >= 0; i--) begin
         if (i == n - 1) begin
            // msb passes straight through
            bin[i] = gray[i];
         end else if (i < n - 1) begin
            bin[i] = gray[i] ^ bin[i + 1];
         end
      end
      return bin;
   endfunction

   // each gray bit is the xor of two neighbouring binary bits
   function automatic logic [MAX_ADDR_W-1:0] bin_to_gray(
      input logic [MAX_ADDR_W-1:0] bin
   );
      return bin ^ (bin >> 1);
   endfunction

endpackage

//--- gray_counter.sv
`timescale 1ns/1ps

module gray_counter import afifo_pkg::*; #(
   parameter int COUNTER_WIDTH = 4
) (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     en,
   output logic [COUNTER_WIDTH-1:0] gray
);

   // binary count runs one step ahead of the gray output
   logic [COUNTER_WIDTH-1:0] bin_cnt;
   logic [MAX_ADDR_W-1:0]    gray_next;

   // gray form of the count that the output moves to next
   assign gray_next = bin_to_gray(MAX_ADDR_W'(bin_cnt));

   // output comes straight from a flop, so only one bit toggles per step
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bin_cnt <= COUNTER_WIDTH'(1);
         gray    <= '0;
      end else if (en) begin
         bin_cnt <= bin_cnt + 1'b1;
         gray    <= gray_next[COUNTER_WIDTH-1:0];
      end
   end

endmodule

//--- asym_dp_mem.sv
`timescale 1ns/1ps

module asym_dp_mem import afifo_pkg::*; #(
   parameter int W_DATA_W = DEF_W_DATA_W,
   parameter int R_DATA_W = DEF_R_DATA_W,
   parameter int W_ADDR_W = DEF_W_ADDR_W,
   parameter int R_ADDR_W = DEF_R_ADDR_W
) (
   input  logic                clk,
   input  logic                w_en,
   input  logic [W_ADDR_W-1:0] w_addr,
   input  logic [W_DATA_W-1:0] w_data,
   input  logic                rd_clk,
   input  logic                rst,
   input  logic                r_en,
   input  logic [R_ADDR_W-1:0] r_addr,
   output logic [R_DATA_W-1:0] r_data
);

   // storage unit is the narrower of the two port widths
   localparam int NARROW_W = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int WIDE_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int RATIO = WIDE_W / NARROW_W;
   localparam int RATIO_LOG2 = $clog2(RATIO);

   // the narrow port has the larger address space
   localparam int MEM_ADDR_W = (W_ADDR_W > R_ADDR_W) ? W_ADDR_W : R_ADDR_W;
   localparam int DEPTH = 1 << MEM_ADDR_W;

   // narrow units per access and the address shift of each port
   localparam int W_UNITS = W_DATA_W / NARROW_W;
   localparam int R_UNITS = R_DATA_W / NARROW_W;
   localparam int W_SHIFT = (W_DATA_W > R_DATA_W) ? RATIO_LOG2 : 0;
   localparam int R_SHIFT = (R_DATA_W > W_DATA_W) ? RATIO_LOG2 : 0;

   logic [NARROW_W-1:0] mem [DEPTH];

   // first narrow entry touched by each port
   logic [MAX_ADDR_W-1:0] w_base;
   logic [MAX_ADDR_W-1:0] r_base;

   assign w_base = MAX_ADDR_W'(w_addr) << W_SHIFT;
   assign r_base = MAX_ADDR_W'(r_addr) << R_SHIFT;

   // write port
   // a wide word is split over consecutive entries, low slice first
   always_ff @(posedge clk) begin
      if (w_en) begin
         for (int i = 0; i < W_UNITS; i++) begin
            mem[MEM_ADDR_W'(w_base + MAX_ADDR_W'(i))] <= w_data[i*NARROW_W +: NARROW_W];
         end
      end
   end

   // read port, registered
   // lowest entry lands in the least significant slice
   always_ff @(posedge rd_clk or posedge rst) begin
      if (rst) begin
         r_data <= '0;
      end else if (r_en) begin
         for (int i = 0; i < R_UNITS; i++) begin
            r_data[i*NARROW_W +: NARROW_W] <= mem[MEM_ADDR_W'(r_base + MAX_ADDR_W'(i))];
         end
      end
   end

endmodule

//--- afifo_asym.sv
`timescale 1ns/1ps

module afifo_asym import afifo_pkg::*; #(
   parameter int W_DATA_W = DEF_W_DATA_W,
   parameter int R_DATA_W = DEF_R_DATA_W,
   parameter int W_ADDR_W = DEF_W_ADDR_W,
   parameter int R_ADDR_W = DEF_R_ADDR_W
) (
   // write side, clk domain
   input  logic                clk,
   input  logic                rst,
   input  logic [W_DATA_W-1:0] data_in,
   input  logic                write_en,
   output logic                full,
   output logic [W_ADDR_W-1:0] level_w,

   // read side, rd_clk domain
   input  logic                rd_clk,
   input  logic                read_en,
   output logic [R_DATA_W-1:0] data_out,
   output logic                empty,
   output logic [R_ADDR_W-1:0] level_r
);

   localparam int W_DEPTH = 1 << W_ADDR_W;

   // low bits the narrower pointer lacks once moved into the wider domain
   localparam int W_PAD = (W_ADDR_W > R_ADDR_W) ? W_ADDR_W - R_ADDR_W : 0;
   localparam int R_PAD = (R_ADDR_W > W_ADDR_W) ? R_ADDR_W - W_ADDR_W : 0;

   // write domain
   logic                  write_en_int;
   logic [W_ADDR_W-1:0]   wptr_gray;
   logic [W_ADDR_W-1:0]   rptr_aligned;
   logic [W_ADDR_W-1:0]   rptr_sync_0;
   logic [W_ADDR_W-1:0]   rptr_sync_1;
   logic [MAX_ADDR_W-1:0] wptr_bin_full;
   logic [MAX_ADDR_W-1:0] rptr_remote_full;
   logic [W_ADDR_W-1:0]   wptr_bin;
   logic [W_ADDR_W-1:0]   rptr_remote_bin;

   // read domain
   logic                  read_en_int;
   logic [R_ADDR_W-1:0]   rptr_gray;
   logic [R_ADDR_W-1:0]   wptr_aligned;
   logic [R_ADDR_W-1:0]   wptr_sync_0;
   logic [R_ADDR_W-1:0]   wptr_sync_1;
   logic [MAX_ADDR_W-1:0] rptr_bin_full;
   logic [MAX_ADDR_W-1:0] wptr_remote_full;
   logic [R_ADDR_W-1:0]   rptr_bin;
   logic [R_ADDR_W-1:0]   wptr_remote_bin;

   // pointer alignment between the two address widths
   // dropping low gray bits gives the gray code of the dropped-down binary,
   // so the coarser pointer still changes one bit at a time
   generate
      if (W_ADDR_W > R_ADDR_W) begin : g_w_wider
         // write counts narrow units, reader sees only complete wide words
         assign wptr_aligned = wptr_gray[W_ADDR_W-1:W_PAD];
         assign rptr_aligned = {rptr_gray, {W_PAD{1'b0}}};
      end else if (R_ADDR_W > W_ADDR_W) begin : g_r_wider
         assign wptr_aligned = {wptr_gray, {R_PAD{1'b0}}};
         assign rptr_aligned = rptr_gray[R_ADDR_W-1:R_PAD];
      end else begin : g_same_w
         assign wptr_aligned = wptr_gray;
         assign rptr_aligned = rptr_gray;
      end
   endgenerate

   // write side

   // writes while full are dropped
   assign write_en_int = write_en & ~full;

   gray_counter #(
      .COUNTER_WIDTH(W_ADDR_W)
   ) i_wptr_counter (
      .clk (clk),
      .rst (rst),
      .en  (write_en_int),
      .gray(wptr_gray)
   );

   // two-flop synchronizer for the read pointer
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rptr_sync_0 <= '0;
         rptr_sync_1 <= '0;
      end else begin
         rptr_sync_0 <= rptr_aligned;
         rptr_sync_1 <= rptr_sync_0;
      end
   end

   assign wptr_bin_full = gray_to_bin(MAX_ADDR_W'(wptr_gray), W_ADDR_W);
   assign wptr_bin = wptr_bin_full[W_ADDR_W-1:0];

   // padding bits are not part of the gray code
   // decode the real bits only and shift them back into place
   assign rptr_remote_full = gray_to_bin(MAX_ADDR_W'(rptr_sync_1 >> W_PAD),
                                         W_ADDR_W - W_PAD) << W_PAD;
   assign rptr_remote_bin = rptr_remote_full[W_ADDR_W-1:0];

   // occupancy in write units, modulo the pointer range
   assign level_w = wptr_bin - rptr_remote_bin;

   // one slot stays unused so that full and empty differ
   assign full = (level_w == W_ADDR_W'(W_DEPTH - 1));

   // read side

   // reads while empty are dropped
   assign read_en_int = read_en & ~empty;

   gray_counter #(
      .COUNTER_WIDTH(R_ADDR_W)
   ) i_rptr_counter (
      .clk (rd_clk),
      .rst (rst),
      .en  (read_en_int),
      .gray(rptr_gray)
   );

   // two-flop synchronizer for the write pointer
   always_ff @(posedge rd_clk or posedge rst) begin
      if (rst) begin
         wptr_sync_0 <= '0;
         wptr_sync_1 <= '0;
      end else begin
         wptr_sync_0 <= wptr_aligned;
         wptr_sync_1 <= wptr_sync_0;
      end
   end

   assign rptr_bin_full = gray_to_bin(MAX_ADDR_W'(rptr_gray), R_ADDR_W);
   assign rptr_bin = rptr_bin_full[R_ADDR_W-1:0];

   assign wptr_remote_full = gray_to_bin(MAX_ADDR_W'(wptr_sync_1 >> R_PAD),
                                         R_ADDR_W - R_PAD) << R_PAD;
   assign wptr_remote_bin = wptr_remote_full[R_ADDR_W-1:0];

   // complete words available to the reader
   assign level_r = wptr_remote_bin - rptr_bin;
   assign empty = (level_r == '0);

   // storage, addressed by the decoded local pointers
   asym_dp_mem #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .W_ADDR_W(W_ADDR_W),
      .R_ADDR_W(R_ADDR_W)
   ) i_mem (
      .clk   (clk),
      .w_en  (write_en_int),
      .w_addr(wptr_bin),
      .w_data(data_in),
      .rd_clk(rd_clk),
      .rst   (rst),
      .r_en  (read_en_int),
      .r_addr(rptr_bin),
      .r_data(data_out)
   );

endmodule

//--- tb_afifo_checks.svh
`ifndef TB_AFIFO_CHECKS_SVH
`define TB_AFIFO_CHECKS_SVH

// running totals over the whole run
int checks = 0;
int errors = 0;

// one read word against the model
task automatic check_word(
   input logic [R_DATA_W-1:0] got,
   input logic [R_DATA_W-1:0] exp,
   input string               what
);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("[ERROR] t=%0t %s: data_out %h, expected %h", $time, what, got, exp);
   end
endtask

// levels of both sides, zero-extended to the wider one
task automatic check_level(
   input logic [LEVEL_W-1:0] got,
   input logic [LEVEL_W-1:0] exp,
   input string              what
);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("[ERROR] t=%0t %s: level %0d, expected %0d", $time, what, got, exp);
   end
endtask

task automatic check_flag(
   input logic  got,
   input logic  exp,
   input string what
);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("[ERROR] t=%0t %s: flag %b, expected %b", $time, what, got, exp);
   end
endtask

`endif

//--- tb_afifo_asym.sv
`timescale 1ns/1ps

module tb_afifo_asym import afifo_pkg::*; ();

   localparam int W_DATA_W = DEF_W_DATA_W;
   localparam int R_DATA_W = DEF_R_DATA_W;
   localparam int W_ADDR_W = DEF_W_ADDR_W;
   localparam int R_ADDR_W = DEF_R_ADDR_W;
   localparam int LEVEL_W = (W_ADDR_W > R_ADDR_W) ? W_ADDR_W : R_ADDR_W;
   localparam int W_DEPTH = 1 << W_ADDR_W;
   // narrow bytes per read word
   localparam int UNITS = R_DATA_W / W_DATA_W;
   localparam int WAIT_LIMIT = 200;
   localparam int N_ROWS = 8;

   logic                clk;
   logic                rst;
   logic [W_DATA_W-1:0] data_in;
   logic                write_en;
   logic                full;
   logic [W_ADDR_W-1:0] level_w;
   logic                rd_clk;
   logic                read_en;
   logic [R_DATA_W-1:0] data_out;
   logic                empty;
   logic [R_ADDR_W-1:0] level_r;

   // bytes written, words read, random data, bytes left once settled
   typedef struct packed {
      logic [7:0]          wr_cnt;
      logic [7:0]          rd_cnt;
      logic                rnd;
      logic [W_ADDR_W-1:0] left;
   } row_t;

   row_t rows [N_ROWS];

   // reference model with one entry per accepted byte
   logic [W_DATA_W-1:0] model_q [$];
   logic [R_DATA_W-1:0] last_word;

   `include "tb_afifo_checks.svh"

   afifo_asym #(
      .W_DATA_W(W_DATA_W),
      .R_DATA_W(R_DATA_W),
      .W_ADDR_W(W_ADDR_W),
      .R_ADDR_W(R_ADDR_W)
   ) i_dut (
      .clk     (clk),
      .rst     (rst),
      .data_in (data_in),
      .write_en(write_en),
      .full    (full),
      .level_w (level_w),
      .rd_clk  (rd_clk),
      .read_en (read_en),
      .data_out(data_out),
      .empty   (empty),
      .level_r (level_r)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // unrelated period so edges drift against clk
   initial begin
      rd_clk = 1'b0;
      forever #17 rd_clk = ~rd_clk;
   end

   // 3 bytes are still pending from the full test when the table starts
   task automatic load_rows();
      rows[0] = '{8'd5, 8'd2, 1'b1, 6'd0};
      rows[1] = '{8'd16, 8'd3, 1'b0, 6'd4};
      rows[2] = '{8'd20, 8'd6, 1'b1, 6'd0};
      rows[3] = '{8'd7, 8'd1, 1'b1, 6'd3};
      rows[4] = '{8'd33, 8'd9, 1'b0, 6'd0};
      rows[5] = '{8'd12, 8'd2, 1'b1, 6'd4};
      rows[6] = '{8'd0, 8'd1, 1'b0, 6'd0};
      rows[7] = '{8'd30, 8'd7, 1'b1, 6'd2};
   endtask

   task automatic end_run();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   endtask

   task automatic abort_wait(input string what);
      errors++;
      $display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
      end_run();
   endtask

   task automatic finish_test(input string name, input int start_errors);
      if (errors == start_errors) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d error(s)", name, errors - start_errors);
      end
   endtask

   // one write_en pulse
   // accept tells whether the FIFO should take it
   task automatic write_byte(input logic [W_DATA_W-1:0] d, input bit accept);
      @(posedge clk);
      #2;
      data_in = d;
      write_en = 1'b1;
      if (accept) begin
         model_q.push_back(d);
      end
      @(posedge clk);
      #2;
      write_en = 1'b0;
   endtask

   task automatic read_word(input string what);
      logic [R_DATA_W-1:0] exp;
      int                  n;

      n = 0;
      @(posedge rd_clk);
      #2;
      while (empty) begin
         if (n == WAIT_LIMIT) begin
            abort_wait({"empty going low before ", what});
         end
         @(posedge rd_clk);
         #2;
         n++;
      end
      read_en = 1'b1;
      @(posedge rd_clk);
      #2;
      read_en = 1'b0;
      // first byte written lands in the low slice
      exp = '0;
      for (int i = 0; i < UNITS; i++) begin
         exp[i*W_DATA_W +: W_DATA_W] = model_q.pop_front();
      end
      last_word = exp;
      check_word(data_out, exp, what);
   endtask

   // a level that never arrives is reported with its last value
   task automatic wait_level_w(input logic [W_ADDR_W-1:0] exp, input string what);
      int n;

      n = 0;
      @(posedge clk);
      #2;
      while (level_w !== exp && n < WAIT_LIMIT) begin
         @(posedge clk);
         #2;
         n++;
      end
      check_level(LEVEL_W'(level_w), LEVEL_W'(exp), what);
      if (level_w !== exp) begin
         abort_wait(what);
      end
   endtask

   task automatic wait_level_r(input logic [R_ADDR_W-1:0] exp, input string what);
      int n;

      n = 0;
      @(posedge rd_clk);
      #2;
      while (level_r !== exp && n < WAIT_LIMIT) begin
         @(posedge rd_clk);
         #2;
         n++;
      end
      check_level(LEVEL_W'(level_r), LEVEL_W'(exp), what);
      if (level_r !== exp) begin
         abort_wait(what);
      end
   endtask

   initial begin
      int e0;

      void'($urandom(32'h5441));
      rst = 1'b1;
      data_in = '0;
      write_en = 1'b0;
      read_en = 1'b0;
      last_word = '0;
      load_rows();
      repeat (2) @(posedge clk);
      #2;
      rst = 1'b0;

      e0 = errors;
      check_flag(empty, 1'b1, "empty after reset");
      check_flag(full, 1'b0, "full after reset");
      check_level(LEVEL_W'(level_w), '0, "level_w after reset");
      check_level(LEVEL_W'(level_r), '0, "level_r after reset");
      check_word(data_out, '0, "data_out after reset");
      finish_test("reset state", e0);

      e0 = errors;
      for (int k = 0; k < 8; k++) begin
         write_byte(W_DATA_W'(8'ha0 + k), 1'b1);
      end
      wait_level_r(R_ADDR_W'(2), "level_r reaching 2 words");
      read_word("first word of eight bytes");
      read_word("second word of eight bytes");
      wait_level_w('0, "level_w draining after two words");
      finish_test("width conversion and order", e0);

      e0 = errors;
      for (int k = 0; k < 3; k++) begin
         write_byte(W_DATA_W'(8'h30 + k), 1'b1);
      end
      // partial word must stay invisible for a while
      repeat (6) begin
         @(posedge rd_clk);
         #2;
         check_level(LEVEL_W'(level_r), '0, "level_r with a partial word");
         check_flag(empty, 1'b1, "empty with a partial word");
      end
      write_byte(W_DATA_W'(8'h33), 1'b1);
      wait_level_r(R_ADDR_W'(1), "level_r after the fourth byte");
      read_word("word completed by the fourth byte");
      wait_level_w('0, "level_w draining after the partial test");
      finish_test("partial words stay hidden", e0);

      e0 = errors;
      for (int k = 0; k < W_DEPTH - 1; k++) begin
         write_byte(W_DATA_W'(k * 3 + 1), 1'b1);
      end
      check_flag(full, 1'b1, "full after 63 bytes");
      for (int k = 0; k < 4; k++) begin
         write_byte(W_DATA_W'(8'hee), 1'b0);
      end
      check_level(LEVEL_W'(level_w), LEVEL_W'(W_DEPTH - 1), "level_w after writes while full");
      wait_level_r(R_ADDR_W'((W_DEPTH - 1) / UNITS), "level_r reaching 15 words");
      for (int k = 0; k < (W_DEPTH - 1) / UNITS; k++) begin
         read_word("word read back after full");
      end
      check_flag(empty, 1'b1, "empty after reading 15 words");
      wait_level_w(W_ADDR_W'((W_DEPTH - 1) % UNITS), "level_w left with 3 bytes");
      finish_test("full flag and ignored writes", e0);

      e0 = errors;
      repeat (4) begin
         @(posedge rd_clk);
         #2;
         read_en = 1'b1;
         @(posedge rd_clk);
         #2;
         read_en = 1'b0;
         check_word(data_out, last_word, "data_out after read while empty");
         check_flag(empty, 1'b1, "empty after read while empty");
      end
      finish_test("ignored reads when empty", e0);

      e0 = errors;
      for (int r = 0; r < N_ROWS; r++) begin
         fork
            begin
               logic [W_DATA_W-1:0] d;

               for (int k = 0; k < rows[r].wr_cnt; k++) begin
                  if (rows[r].rnd) begin
                     d = W_DATA_W'($urandom);
                  end else begin
                     d = W_DATA_W'(r * 40 + k);
                  end
                  write_byte(d, 1'b1);
               end
            end
            begin
               for (int k = 0; k < rows[r].rd_cnt; k++) begin
                  read_word($sformatf("table row %0d word %0d", r, k));
               end
            end
         join
         wait_level_w(rows[r].left, $sformatf("level_w settling after row %0d", r));
      end
      finish_test("table-driven interleaving", e0);

      end_run();
   end

endmodule

//--- afifo_asym.f
+incdir+.
afifo_pkg.sv
gray_counter.sv
asym_dp_mem.sv
afifo_asym.sv
tb_afifo_asym.sv

//--- Bender.yml
package:
  name: afifo_asym

sources:
  # package first, then the RTL from the leaves up to the top level
  - afifo_pkg.sv
  - gray_counter.sv
  - asym_dp_mem.sv
  - afifo_asym.sv

  # testbench with its included compare tasks
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_afifo_asym.sv
